// File: testbench/buffer_patterns.txt
# op size port prio start, where a read gives the expected block length as its size
# start is the expected first address in decimal, FAIL for a refused write
W 16 0 0 0
W 32 0 0 16
W 8 1 2 48
W 24 0 0 56
R 16 0 0 0
R 32 0 0 16
W 44 2 1 0
R 8 1 2 48
W 64 3 3 80
W 64 3 3 144
W 50 2 0 FAIL
W 48 2 0 208
W 1 0 1 44
W 1 0 1 45
W 1 0 1 46
W 1 0 1 47
W 1 1 0 48
W 1 1 0 49
W 1 1 0 50
W 1 1 0 51
W 1 1 1 52
W 2 1 1 FAIL
W 3 0 1 FAIL
W 3 1 1 53
R 1 0 1 44

// File: project.f
common/buffer_pkg.sv
hw/block_table/block_table.sv
hw/burst_counter.sv
hw/queue_store.sv
hw/alloc_fsm.sv
hw/buffer_manager.sv
testbench/tb_buffer_manager.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the buffer manager testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

top=tb_buffer_manager
log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$top" -f project.f -o "sim_$top"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./obj_dir/sim_$top" 2>&1 | tee "$log"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: testbench/tb_buffer_manager.sv
/* testbench for buffer_manager, stimulus from testbench/buffer_patterns.txt.
   operations run one at a time; a free-list model predicts every address */
`timescale 1ns/1ps

module tb_buffer_manager;

    localparam int max_ops  = 64;
    localparam int num_qs   = buffer_pkg::num_ports * buffer_pkg::num_prios;
    localparam int depth    = buffer_pkg::queue_depth;

    logic                             clk = 1'b0;
    logic                             rst;
    logic                             wr_valid;
    logic                             wr_ready;
    buffer_pkg::len_t                 wr_size;
    buffer_pkg::port_t                wr_port;
    buffer_pkg::prio_t                wr_prio;
    buffer_pkg::addr_t                write_address;
    logic                             writing;
    logic                             alloc_fail;
    logic [buffer_pkg::num_ports-1:0] rd_req;
    buffer_pkg::prio_t                rd_prio [buffer_pkg::num_ports];
    logic [buffer_pkg::num_ports-1:0] reading;
    buffer_pkg::addr_t                read_addr [buffer_pkg::num_ports];

    byte op_code  [max_ops];  // W or R
    int  op_size  [max_ops];  // request size, or block length for a read
    int  op_port  [max_ops];
    int  op_prio  [max_ops];
    int  op_start [max_ops];  // -1 when the write must be refused
    int  num_ops;

    // reference model, blocks in address order
    int blk_start [buffer_pkg::num_nodes];
    int blk_len   [buffer_pkg::num_nodes];
    bit blk_used  [buffer_pkg::num_nodes];
    int num_blks;
    int q_start [num_qs * depth];  // queued block starts
    int q_head  [num_qs];
    int q_count [num_qs];

    int cycles      = 0;
    int cycle_limit = 1000;

    buffer_manager DUT (
        .clk, .rst, .wr_valid, .wr_ready, .wr_size, .wr_port, .wr_prio,
        .write_address, .writing, .alloc_fail, .rd_req, .rd_prio, .reading, .read_addr
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the operations did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    // decimal digits of a scanned token
    function automatic int to_number(input logic [63:0] s);
        int v;
        v = 0;
        for (int i = 7; i >= 0; i--) begin
            if (s[i*8 +: 8] >= "0" && s[i*8 +: 8] <= "9") begin
                v = v * 10 + int'(s[i*8 +: 8] - "0");
            end
        end
        return v;
    endfunction

    task automatic load_patterns();
        int               fd;
        int               code;
        int               size;
        int               port;
        int               prio;
        logic [8*16-1:0]  tok;
        logic [8*16-1:0]  start_tok;
        logic [8*128-1:0] rest;
        num_ops = 0;
        fd = $fopen("testbench/buffer_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/buffer_patterns.txt");
            stop_with_failure();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);  // skip comment
            end else begin
                code = $fscanf(fd, "%d %d %d %s", size, port, prio, start_tok);
                if (code != 4 || num_ops == max_ops) begin
                    $display("pattern line %0d is malformed or one too many", num_ops + 1);
                    stop_with_failure();
                end
                op_code[num_ops]  = tok[7:0];
                op_size[num_ops]  = size;
                op_port[num_ops]  = port;
                op_prio[num_ops]  = prio;
                op_start[num_ops] = (start_tok == "FAIL") ? -1 : to_number(start_tok[63:0]);
                num_ops++;
            end
        end
        $fclose(fd);
        // node walk plus longest burst per line, and per block drained at the end
        cycle_limit = 16 + 300 * (num_ops + buffer_pkg::num_nodes - 1);
    endtask

    // first fit, low part of a larger block; start is -1 on refusal
    task automatic first_fit_alloc(input int size, input int qi, output int start);
        int hit;
        hit   = -1;
        start = -1;
        for (int i = num_blks - 1; i >= 0; i--) begin
            if (!blk_used[i] && blk_len[i] >= size) begin
                hit = i;
            end
        end
        if (hit >= 0 && q_count[qi] < depth
            && (blk_len[hit] == size || num_blks < buffer_pkg::num_nodes - 1)) begin
            if (blk_len[hit] != size) begin
                for (int i = num_blks; i > hit + 1; i--) begin
                    blk_start[i] = blk_start[i-1];
                    blk_len[i]   = blk_len[i-1];
                    blk_used[i]  = blk_used[i-1];
                end
                blk_start[hit+1] = blk_start[hit] + size;  // free remainder
                blk_len[hit+1]   = blk_len[hit] - size;
                blk_used[hit+1]  = 1'b0;
                blk_len[hit]     = size;
                num_blks++;
            end
            blk_used[hit] = 1'b1;
            start         = blk_start[hit];
            q_start[qi * depth + (q_head[qi] + q_count[qi]) % depth] = start;
            q_count[qi]++;
        end
    endtask

    task automatic free_and_merge(input int qi, output int start, output int len);
        int i;
        start       = q_start[qi * depth + q_head[qi]];
        q_head[qi]  = (q_head[qi] + 1) % depth;
        q_count[qi] = q_count[qi] - 1;
        len         = 0;
        for (i = 0; i < num_blks; i++) begin
            if (blk_start[i] == start) begin
                len         = blk_len[i];
                blk_used[i] = 1'b0;
            end
        end
        i = 0;
        while (i < num_blks - 1) begin
            if (!blk_used[i] && !blk_used[i+1]) begin
                blk_len[i] = blk_len[i] + blk_len[i+1];
                for (int j = i + 1; j < num_blks - 1; j++) begin
                    blk_start[j] = blk_start[j+1];
                    blk_len[j]   = blk_len[j+1];
                    blk_used[j]  = blk_used[j+1];
                end
                num_blks--;
            end else begin
                i++;
            end
        end
    endtask

    task automatic write_and_check(input int size, input int port, input int prio,
                                   input int start);
        wr_valid = 1'b1;
        wr_size  = buffer_pkg::len_t'(size);
        wr_port  = buffer_pkg::port_t'(port);
        wr_prio  = buffer_pkg::prio_t'(prio);
        @(negedge clk);
        while (!wr_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        wr_valid = 1'b0;  // taken on that edge
        @(negedge clk);
        while (!writing && !alloc_fail) begin
            @(negedge clk);
        end
        check_value("alloc_fail", alloc_fail, int'(start < 0));
        if (start < 0) begin
            check_value("writing", writing, 0);
            @(negedge clk);
            check_value("alloc_fail", alloc_fail, 0);  // single cycle pulse
            check_value("writing", writing, 0);
        end else begin
            for (int i = 0; i < size; i++) begin
                check_value("writing", writing, 1);
                check_value("write_address", write_address, start + i);
                @(negedge clk);
            end
            check_value("writing", writing, 0);
        end
    endtask

    task automatic read_and_check(input int port, input int prio, input int start,
                                  input int len);
        string addr_name;
        addr_name     = $sformatf("read_addr[%0d]", port);
        rd_req[port]  = 1'b1;
        rd_prio[port] = buffer_pkg::prio_t'(prio);
        @(negedge clk);
        while (!reading[port]) begin
            @(negedge clk);
        end
        check_value("reading", reading, 1 << port);
        check_value(addr_name, read_addr[port], start);
        @(posedge clk);
        #1;
        rd_req[port] = 1'b0;
        for (int i = 1; i < len; i++) begin
            @(negedge clk);
            check_value("reading", reading, 1 << port);
            check_value(addr_name, read_addr[port], start + i);
        end
        @(negedge clk);
        check_value("reading", reading, 0);
    endtask

    initial begin
        int qi;
        int start;
        int len;
        rst      = 1'b1;
        wr_valid = 1'b0;
        wr_size  = '0;
        wr_port  = '0;
        wr_prio  = '0;
        rd_req   = '0;
        for (int p = 0; p < buffer_pkg::num_ports; p++) begin
            rd_prio[p] = '0;
        end
        num_blks     = 1;  // one free block over the whole memory
        blk_start[0] = 0;
        blk_len[0]   = buffer_pkg::mem_words;
        blk_used[0]  = 1'b0;
        for (int q = 0; q < num_qs; q++) begin
            q_head[q]  = 0;
            q_count[q] = 0;
        end
        load_patterns();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("wr_ready", wr_ready, 1);
        check_value("writing", writing, 0);
        check_value("alloc_fail", alloc_fail, 0);
        check_value("reading", reading, 0);
        for (int k = 0; k < num_ops; k++) begin
            qi = op_port[k] * buffer_pkg::num_prios + op_prio[k];
            @(posedge clk);
            #1;
            if (op_code[k] == "W") begin
                first_fit_alloc(op_size[k], qi, start);
                check_value("pattern start vs model", op_start[k], start);
                write_and_check(op_size[k], op_port[k], op_prio[k], start);
            end else if (op_code[k] == "R" && q_count[qi] > 0) begin
                free_and_merge(qi, start, len);
                check_value("pattern start vs model", op_start[k], start);
                check_value("pattern length vs model", op_size[k], len);
                read_and_check(op_port[k], op_prio[k], start, len);
            end else begin
                $display("pattern line %0d is neither a write nor a read of a filled queue",
                         k + 1);
                stop_with_failure();
            end
        end
        // drain the queues left by the patterns, every port in turn
        for (int q = 0; q < num_qs; q++) begin
            while (q_count[q] > 0) begin
                @(posedge clk);
                #1;
                free_and_merge(q, start, len);
                read_and_check(q / buffer_pkg::num_prios, q % buffer_pkg::num_prios,
                               start, len);
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: hw/buffer_manager.sv
/* packet buffer manager top. one write stream and one read stream per port;
   address streams have no back-pressure */
`timescale 1ns/1ps

module buffer_manager (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wr_valid,
    output logic                             wr_ready,
    input  buffer_pkg::len_t                 wr_size,
    input  buffer_pkg::port_t                wr_port,
    input  buffer_pkg::prio_t                wr_prio,
    output buffer_pkg::addr_t                write_address,
    output logic                             writing,
    output logic                             alloc_fail,
    input  logic [buffer_pkg::num_ports-1:0] rd_req,
    input  buffer_pkg::prio_t                rd_prio [buffer_pkg::num_ports],
    output logic [buffer_pkg::num_ports-1:0] reading,
    output buffer_pkg::addr_t                read_addr [buffer_pkg::num_ports]
);

    buffer_pkg::node_t     cur_node, cur_next, tbl_node, spare_node, head_node, push_node;
    buffer_pkg::table_op_t tbl_op;
    buffer_pkg::len_t      tbl_len, cur_len, burst_len;
    buffer_pkg::addr_t     cur_start, burst_base;
    buffer_pkg::port_t     q_port;
    buffer_pkg::prio_t     q_prio;
    logic                  cur_used, cur_mergeable, spare_ok;
    logic                  push, pop, q_empty, q_full, wr_start;
    logic [buffer_pkg::num_ports-1:0] rd_start;

    block_table u_table (
        .clk, .rst, .cur_node, .tbl_op, .tbl_len, .tbl_node,
        .cur_start, .cur_len, .cur_used, .cur_next, .cur_mergeable,
        .spare_node, .spare_ok
    );

    alloc_fsm u_fsm (
        .clk, .rst, .wr_valid, .wr_size, .wr_port, .wr_prio,
        .rd_req, .rd_prio, .reading,
        .cur_start, .cur_len, .cur_used, .cur_next, .cur_mergeable,
        .spare_node, .spare_ok, .head_node, .q_empty, .q_full,
        .wr_ready, .alloc_fail, .cur_node, .tbl_op, .tbl_len, .tbl_node,
        .q_port, .q_prio, .push, .push_node, .pop,
        .wr_start, .rd_start, .burst_base, .burst_len
    );

    queue_store u_queues (
        .clk, .rst, .q_port, .q_prio, .push, .push_node, .pop,
        .head_node, .q_empty, .q_full
    );

    burst_counter u_wr_burst (
        .clk, .rst, .start(wr_start), .base(burst_base), .len(burst_len),
        .active(writing), .addr(write_address)
    );

    for (genvar p = 0; p < buffer_pkg::num_ports; p++) begin : g_rd_burst
        burst_counter u_rd_burst (
            .clk, .rst, .start(rd_start[p]), .base(burst_base), .len(burst_len),
            .active(reading[p]), .addr(read_addr[p])
        );
    end

endmodule

// File: hw/alloc_fsm.sv
/* serializes allocations, read-outs and merges; one list node per cycle.
   a pending read on an empty queue does not block writes */
`timescale 1ns/1ps

module alloc_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_valid,
    input  buffer_pkg::len_t              wr_size,
    input  buffer_pkg::port_t             wr_port,
    input  buffer_pkg::prio_t             wr_prio,
    input  logic [buffer_pkg::num_ports-1:0] rd_req,
    input  buffer_pkg::prio_t             rd_prio [buffer_pkg::num_ports],
    input  logic [buffer_pkg::num_ports-1:0] reading,
    input  buffer_pkg::addr_t             cur_start,
    input  buffer_pkg::len_t              cur_len,
    input  logic                          cur_used,
    input  buffer_pkg::node_t             cur_next,
    input  logic                          cur_mergeable,
    input  buffer_pkg::node_t             spare_node,
    input  logic                          spare_ok,
    input  buffer_pkg::node_t             head_node,
    input  logic                          q_empty,
    input  logic                          q_full,
    output logic                          wr_ready,
    output logic                          alloc_fail,
    output buffer_pkg::node_t             cur_node,
    output buffer_pkg::table_op_t         tbl_op,
    output buffer_pkg::len_t              tbl_len,
    output buffer_pkg::node_t             tbl_node,
    output buffer_pkg::port_t             q_port,
    output buffer_pkg::prio_t             q_prio,
    output logic                          push,
    output buffer_pkg::node_t             push_node,
    output logic                          pop,
    output logic                          wr_start,
    output logic [buffer_pkg::num_ports-1:0] rd_start,
    output buffer_pkg::addr_t             burst_base,
    output buffer_pkg::len_t              burst_len
);

    buffer_pkg::fsm_state_t state;
    buffer_pkg::port_t      sel_port;  // queue of the operation in flight
    buffer_pkg::prio_t      sel_prio;
    buffer_pkg::len_t       req_size;
    buffer_pkg::port_t      cand;
    logic                   cand_valid;
    logic                   read_start;
    logic                   fits, exact, grant_ok, fail;

    // lowest port with a request that is not already streaming
    always_comb begin
        cand       = '0;
        cand_valid = 1'b0;
        for (int i = buffer_pkg::num_ports - 1; i >= 0; i--) begin
            if (rd_req[i] && !reading[i]) begin
                cand       = buffer_pkg::port_t'(i);
                cand_valid = 1'b1;
            end
        end
    end

    assign q_port     = (state == buffer_pkg::st_idle) ? cand : sel_port;
    assign q_prio     = (state == buffer_pkg::st_idle) ? rd_prio[cand] : sel_prio;
    assign read_start = (state == buffer_pkg::st_idle) && cand_valid && !q_empty;
    assign wr_ready   = (state == buffer_pkg::st_idle) && !read_start;

    assign fits     = !cur_used && (cur_len >= req_size);
    assign exact    = cur_len == req_size;
    assign grant_ok = fits && !q_full && (exact || spare_ok);
    assign fail     = fits ? !grant_ok : (cur_next == buffer_pkg::null_node);

    assign push_node  = cur_node;  // granted block keeps its node
    assign burst_base = cur_start;
    assign burst_len  = (state == buffer_pkg::st_free) ? cur_len : req_size;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= buffer_pkg::st_idle;
            cur_node <= '0;
        end else begin
            case (state)
                buffer_pkg::st_idle: begin
                    if (read_start) begin
                        state <= buffer_pkg::st_lookup;
                    end else if (wr_valid) begin
                        state    <= buffer_pkg::st_search;
                        cur_node <= '0;  // first fit starts at the head
                    end
                end
                buffer_pkg::st_search: begin
                    if (grant_ok) begin
                        state <= buffer_pkg::st_grant;
                    end else if (fail) begin
                        state <= buffer_pkg::st_idle;
                    end else begin
                        cur_node <= cur_next;
                    end
                end
                buffer_pkg::st_lookup: begin
                    cur_node <= head_node;
                    state    <= buffer_pkg::st_free;
                end
                buffer_pkg::st_free: begin
                    cur_node <= '0;
                    state    <= buffer_pkg::st_merge;
                end
                buffer_pkg::st_merge: begin
                    if (!cur_mergeable) begin  // stay put while absorbing
                        if (cur_next == buffer_pkg::null_node) begin
                            state <= buffer_pkg::st_idle;
                        end else begin
                            cur_node <= cur_next;
                        end
                    end
                end
                default: state <= buffer_pkg::st_idle;  // st_grant ends here
            endcase
        end
    end

    // request fields, captured on the accepting idle cycle
    always_ff @(posedge clk) begin
        if (state == buffer_pkg::st_idle) begin
            if (read_start) begin
                sel_port <= cand;
                sel_prio <= rd_prio[cand];
            end else begin
                sel_port <= wr_port;
                sel_prio <= wr_prio;
                req_size <= wr_size;
            end
        end
    end

    always_comb begin
        tbl_op     = buffer_pkg::op_nop;
        tbl_len    = req_size;
        tbl_node   = spare_node;
        push       = 1'b0;
        pop        = 1'b0;
        wr_start   = 1'b0;
        rd_start   = '0;
        alloc_fail = 1'b0;
        case (state)
            buffer_pkg::st_search: alloc_fail = fail;
            buffer_pkg::st_grant: begin
                tbl_op   = exact ? buffer_pkg::op_take : buffer_pkg::op_split;
                push     = 1'b1;
                wr_start = 1'b1;
            end
            buffer_pkg::st_lookup: pop = 1'b1;
            buffer_pkg::st_free: begin
                tbl_op             = buffer_pkg::op_free;
                rd_start[sel_port] = 1'b1;
            end
            buffer_pkg::st_merge: begin
                if (cur_mergeable) begin
                    tbl_op = buffer_pkg::op_merge;
                end
            end
            default: ;
        endcase
    end

    // q_full was checked during the search, the queue must not fill meanwhile
    assert property (@(posedge clk) disable iff (rst) push |-> !q_full);
    assert property (@(posedge clk) disable iff (rst)
        (state == buffer_pkg::st_search) |-> (cur_node != buffer_pkg::null_node));

endmodule

// File: hw/queue_store.sv
/* one circular FIFO of node indexes per port and priority.
   only the selected queue is visible; push and pop are not checked for overflow */
`timescale 1ns/1ps

module queue_store (
    input  logic              clk,
    input  logic              rst,
    input  buffer_pkg::port_t q_port,
    input  buffer_pkg::prio_t q_prio,
    input  logic              push,
    input  buffer_pkg::node_t push_node,
    input  logic              pop,
    output buffer_pkg::node_t head_node,
    output logic              q_empty,
    output logic              q_full
);

    buffer_pkg::node_t fifo_mem [buffer_pkg::num_ports][buffer_pkg::num_prios]
                                [buffer_pkg::queue_depth];
    logic [$clog2(buffer_pkg::queue_depth)-1:0] rd_ptr [buffer_pkg::num_ports]
                                                       [buffer_pkg::num_prios];
    logic [$clog2(buffer_pkg::queue_depth)-1:0] wr_ptr [buffer_pkg::num_ports]
                                                       [buffer_pkg::num_prios];
    buffer_pkg::qcount_t count [buffer_pkg::num_ports][buffer_pkg::num_prios];

    assign head_node = fifo_mem[q_port][q_prio][rd_ptr[q_port][q_prio]];
    assign q_empty   = count[q_port][q_prio] == '0;
    assign q_full    = count[q_port][q_prio] == buffer_pkg::qcount_t'(buffer_pkg::queue_depth);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[q_port][q_prio][wr_ptr[q_port][q_prio]] <= push_node;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < buffer_pkg::num_ports; p++) begin
                for (int q = 0; q < buffer_pkg::num_prios; q++) begin
                    rd_ptr[p][q] <= '0;
                    wr_ptr[p][q] <= '0;
                    count[p][q]  <= '0;
                end
            end
        end else begin
            if (push) begin
                wr_ptr[q_port][q_prio] <= wr_ptr[q_port][q_prio] + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr[q_port][q_prio] <= rd_ptr[q_port][q_prio] + 1'b1;
            end
            case ({push, pop})
                2'b10:   count[q_port][q_prio] <= count[q_port][q_prio] + 1'b1;
                2'b01:   count[q_port][q_prio] <= count[q_port][q_prio] - 1'b1;
                default: ;
            endcase
        end
    end

    // the controller only pops a queue it saw non-empty in the cycle before
    assert property (@(posedge clk) disable iff (rst) pop |-> !q_empty);

endmodule

// File: hw/burst_counter.sv
/* streams len consecutive addresses from base, one per cycle.
   a start while active restarts the burst */
`timescale 1ns/1ps

module burst_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  buffer_pkg::addr_t base,
    input  buffer_pkg::len_t  len,
    output logic              active,
    output buffer_pkg::addr_t addr
);

    buffer_pkg::len_t remain;  // addresses left including the current one

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            remain <= '0;
        end else if (start) begin
            active <= 1'b1;
            remain <= len;
            addr   <= base;
        end else if (active) begin
            if (remain == buffer_pkg::len_t'(1)) begin
                active <= 1'b0;  // last address was shown
            end else begin
                addr <= addr + 1'b1;
            end
            remain <= remain - 1'b1;
        end
    end

endmodule

// File: hw/block_table/block_table.sv
/* address-ordered doubly linked list of memory blocks; node 0 is always the head.
   a split keeps the low part in cur_node and puts the remainder in tbl_node */
`timescale 1ns/1ps

module block_table (
    input  logic                  clk,
    input  logic                  rst,
    input  buffer_pkg::node_t     cur_node,
    input  buffer_pkg::table_op_t tbl_op,
    input  buffer_pkg::len_t      tbl_len,
    input  buffer_pkg::node_t     tbl_node,
    output buffer_pkg::addr_t     cur_start,
    output buffer_pkg::len_t      cur_len,
    output logic                  cur_used,
    output buffer_pkg::node_t     cur_next,
    output logic                  cur_mergeable,
    output buffer_pkg::node_t     spare_node,
    output logic                  spare_ok
);

    buffer_pkg::addr_t start_q [buffer_pkg::num_nodes];
    buffer_pkg::len_t  len_q   [buffer_pkg::num_nodes];
    buffer_pkg::node_t prev_q  [buffer_pkg::num_nodes];
    buffer_pkg::node_t next_q  [buffer_pkg::num_nodes];
    logic [buffer_pkg::num_nodes-1:0] used_q;   // block holds a packet
    logic [buffer_pkg::num_nodes-1:0] alloc_q;  // node is linked into the list

    buffer_pkg::node_t after_next;
    int                len_total;
    logic              links_ok;

    assign cur_start  = start_q[cur_node];
    assign cur_len    = len_q[cur_node];
    assign cur_used   = used_q[cur_node];
    assign cur_next   = next_q[cur_node];
    assign after_next = next_q[cur_next];

    // both this block and its successor are free
    assign cur_mergeable = !used_q[cur_node] && (cur_next != buffer_pkg::null_node)
                           && !used_q[cur_next];

    // lowest node not in the list, node 0 never qualifies
    always_comb begin
        spare_node = buffer_pkg::null_node;
        spare_ok   = 1'b0;
        for (int i = buffer_pkg::num_nodes - 2; i >= 1; i--) begin
            if (!alloc_q[i]) begin
                spare_node = buffer_pkg::node_t'(i);
                spare_ok   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < buffer_pkg::num_nodes; i++) begin
                prev_q[i] <= buffer_pkg::null_node;
                next_q[i] <= buffer_pkg::null_node;
            end
            used_q     <= '0;
            alloc_q    <= buffer_pkg::num_nodes'(1);  // only the head
            start_q[0] <= '0;
            len_q[0]   <= buffer_pkg::len_t'(buffer_pkg::mem_words);
        end else begin
            case (tbl_op)
                buffer_pkg::op_take: used_q[cur_node] <= 1'b1;
                buffer_pkg::op_split: begin
                    start_q[tbl_node] <= cur_start + buffer_pkg::addr_t'(tbl_len);
                    len_q[tbl_node]   <= cur_len - tbl_len;  // high remainder
                    used_q[tbl_node]  <= 1'b0;
                    alloc_q[tbl_node] <= 1'b1;
                    prev_q[tbl_node]  <= cur_node;
                    next_q[tbl_node]  <= cur_next;
                    if (cur_next != buffer_pkg::null_node) begin
                        prev_q[cur_next] <= tbl_node;
                    end
                    len_q[cur_node]  <= tbl_len;
                    used_q[cur_node] <= 1'b1;
                    next_q[cur_node] <= tbl_node;
                end
                buffer_pkg::op_free: used_q[cur_node] <= 1'b0;
                buffer_pkg::op_merge: begin
                    len_q[cur_node]   <= cur_len + len_q[cur_next];
                    next_q[cur_node]  <= after_next;
                    alloc_q[cur_next] <= 1'b0;  // absorbed node is spare again
                    if (after_next != buffer_pkg::null_node) begin
                        prev_q[after_next] <= cur_node;
                    end
                end
                default: ;
            endcase
        end
    end

    // walk the list from the head, summing lengths and checking back links
    always_comb begin
        buffer_pkg::node_t n;
        int                total;
        total    = 0;
        links_ok = 1'b1;
        n        = '0;
        for (int i = 0; i < buffer_pkg::num_nodes; i++) begin
            if (n != buffer_pkg::null_node) begin
                total = total + int'(len_q[n]);
                if (next_q[n] != buffer_pkg::null_node && prev_q[next_q[n]] != n) begin
                    links_ok = 1'b0;
                end
                n = next_q[n];
            end
        end
        len_total = total;
    end

    assert property (@(posedge clk) disable iff (rst)
        (len_total == buffer_pkg::mem_words) && links_ok);

endmodule

// File: common/buffer_pkg.sv
/* sizes, field types and encodings shared by the buffer manager.
   queue_depth must be a power of two; node 15 is the list terminator */
package buffer_pkg;

    localparam int mem_words   = 256;  // packet memory words
    localparam int num_nodes   = 16;
    localparam int num_ports   = 4;
    localparam int num_prios   = 4;
    localparam int queue_depth = 4;    // entries per port/priority queue
    localparam int max_packet  = 64;   // largest write request in words

    typedef logic [7:0] addr_t;
    typedef logic [8:0] len_t;         // 1 to 256 words
    typedef logic [3:0] node_t;
    typedef logic [1:0] port_t;
    typedef logic [1:0] prio_t;
    typedef logic [2:0] qcount_t;

    localparam node_t null_node = 4'd15;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_search,  // first-fit walk, one node per cycle
        st_grant,
        st_lookup,
        st_free,
        st_merge    // coalescing walk after a free
    } fsm_state_t;

    // block table operations on cur_node
    typedef enum logic [2:0] {
        op_nop,
        op_take,
        op_split,
        op_free,
        op_merge
    } table_op_t;

endpackage
